//--- logic/isa_pkg.sv
// RV32I instruction formats and field codes, imported wherever raw instruction words are handled
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcodes handled by this stage
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111
    } opcode_t;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch conditions, 010 and 011 are reserved
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000; // SUB, SRA, SRAI

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    // One instruction word, three ways of reading it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
    } instr_u;

endpackage

//--- logic/exec_pkg.sv
// Micro-operation encoding passed from decode to execute and on to the result stage
package exec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_ALWAYS  // JALR
    } br_cond_t;

    // Conditional branches and JALR both use UNIT_JUMP
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_JUMP,
        UNIT_ILLEGAL
    } unit_t;

    typedef struct packed {
        unit_t    unit;
        alu_op_t  alu_op;
        br_cond_t br_cond;
        logic     use_imm;  // Operand B from immediate
    } uop_t;

endpackage

//--- logic/exec_ifs.sv
// Stage-to-stage links of the execute pipeline, decode to execute and execute to result
interface dec_ex_if;
    import isa_pkg::*;
    import exec_pkg::*;

    logic      valid;
    uop_t      uop;
    reg_addr_t rd;
    word_t     operand_a;  // rs1
    word_t     operand_b;  // rs2
    word_t     imm;        // Already sign-extended
    word_t     pc;

    modport sender (
        output valid, uop, rd, operand_a, operand_b, imm, pc
    );

    modport receiver (
        input valid, uop, rd, operand_a, operand_b, imm, pc
    );
endinterface

interface ex_res_if;
    import isa_pkg::*;
    import exec_pkg::*;

    logic      valid;
    unit_t     unit;
    reg_addr_t rd;
    word_t     alu_value;
    word_t     link_value;  // pc + 4
    logic      taken;
    word_t     target;

    modport sender (
        output valid, unit, rd, alu_value, link_value, taken, target
    );

    modport receiver (
        input valid, unit, rd, alu_value, link_value, taken, target
    );
endinterface

//--- logic/instr_decoder.sv
// Decode stage; splits an issued instruction into a micro-operation and registers it for execute
module instr_decoder (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           issue_valid_i,
    input  isa_pkg::instr_u instr_i,
    input  isa_pkg::word_t pc_i,
    input  isa_pkg::word_t rs1_val_i,
    input  isa_pkg::word_t rs2_val_i,
    dec_ex_if.sender       dec_o
);
    import isa_pkg::*;
    import exec_pkg::*;

    uop_t      uop_d;
    word_t     imm_d;
    reg_addr_t rd_d;
    word_t     i_imm;
    word_t     b_imm;
    logic      alt_r;
    logic      alt_i;

    function automatic alu_op_t alu_op_of(input logic [2:0] funct3, input logic alt);
        alu_op_t op;
        case (funct3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    assign i_imm = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    assign b_imm = {{20{instr_i.b.imm_12}}, instr_i.b.imm_11, instr_i.b.imm_10_5,
                    instr_i.b.imm_4_1, 1'b0};

    // Bit 30 marks SUB and SRA
    assign alt_r = (instr_i.r.funct7 & F7_ALT) != '0;
    // ADDI has no subtract form, only SRAI looks at bit 30
    assign alt_i = (instr_i.i.funct3 == F3_SRL_SRA) && ((instr_i.i.imm[11:5] & F7_ALT) != '0);

    always_comb begin
        uop_d.unit    = UNIT_ALU;
        uop_d.alu_op  = ALU_ADD;
        uop_d.br_cond = BR_NONE;
        uop_d.use_imm = 1'b0;
        imm_d         = i_imm;
        rd_d          = instr_i.r.rd;

        case (instr_i.r.opcode)
            OPC_OP: begin
                uop_d.alu_op = alu_op_of(instr_i.r.funct3, alt_r);
            end
            OPC_OP_IMM: begin
                uop_d.alu_op  = alu_op_of(instr_i.i.funct3, alt_i);
                uop_d.use_imm = 1'b1;
                if (instr_i.i.funct3 == F3_SLL || instr_i.i.funct3 == F3_SRL_SRA) begin
                    imm_d = {27'd0, instr_i.i.imm[4:0]};  // shamt
                end
            end
            OPC_BRANCH: begin
                uop_d.unit = UNIT_JUMP;
                imm_d      = b_imm;
                rd_d       = '0;  // Bits 11:7 are immediate, nothing to write
                case (instr_i.b.funct3)
                    F3_BEQ:  uop_d.br_cond = BR_EQ;
                    F3_BNE:  uop_d.br_cond = BR_NE;
                    F3_BLT:  uop_d.br_cond = BR_LT;
                    F3_BGE:  uop_d.br_cond = BR_GE;
                    F3_BLTU: uop_d.br_cond = BR_LTU;
                    F3_BGEU: uop_d.br_cond = BR_GEU;
                    default: uop_d.unit    = UNIT_ILLEGAL;
                endcase
            end
            OPC_JALR: begin
                uop_d.unit    = UNIT_JUMP;
                uop_d.br_cond = BR_ALWAYS;
                uop_d.use_imm = 1'b1;
            end
            default: begin
                uop_d.unit = UNIT_ILLEGAL;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_o.valid <= 1'b0;
        end else begin
            dec_o.valid <= issue_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        dec_o.uop       <= uop_d;
        dec_o.rd        <= rd_d;
        dec_o.operand_a <= rs1_val_i;
        dec_o.operand_b <= rs2_val_i;
        dec_o.imm       <= imm_d;
        dec_o.pc        <= pc_i;
    end

endmodule

//--- logic/exec_unit.sv
// Execute stage; ALU, branch comparator and target adder, purely combinational between the links
module exec_unit (
    dec_ex_if.receiver dec_i,
    ex_res_if.sender   res_o
);
    import isa_pkg::*;
    import exec_pkg::*;

    word_t      op_b;
    word_t      alu_value;
    word_t      base;
    word_t      sum;
    logic [4:0] shamt;
    logic       lt;
    logic       ltu;
    logic       eq;
    logic       cond;
    logic       is_jalr;

    assign op_b  = dec_i.uop.use_imm ? dec_i.imm : dec_i.operand_b;
    assign shamt = op_b[4:0];

    // Branches never use the immediate here, so op_b is rs2 for them
    assign lt  = $signed(dec_i.operand_a) < $signed(op_b);
    assign ltu = dec_i.operand_a < op_b;
    assign eq  = dec_i.operand_a == op_b;

    always_comb begin
        case (dec_i.uop.alu_op)
            ALU_ADD:  alu_value = dec_i.operand_a + op_b;
            ALU_SUB:  alu_value = dec_i.operand_a - op_b;
            ALU_SLL:  alu_value = dec_i.operand_a << shamt;
            ALU_SLT:  alu_value = {31'd0, lt};
            ALU_SLTU: alu_value = {31'd0, ltu};
            ALU_XOR:  alu_value = dec_i.operand_a ^ op_b;
            ALU_SRL:  alu_value = dec_i.operand_a >> shamt;
            ALU_SRA:  alu_value = $signed(dec_i.operand_a) >>> shamt;
            ALU_OR:   alu_value = dec_i.operand_a | op_b;
            default:  alu_value = dec_i.operand_a & op_b;
        endcase
    end

    always_comb begin
        case (dec_i.uop.br_cond)
            BR_EQ:     cond = eq;
            BR_NE:     cond = !eq;
            BR_LT:     cond = lt;
            BR_GE:     cond = !lt;
            BR_LTU:    cond = ltu;
            BR_GEU:    cond = !ltu;
            BR_ALWAYS: cond = 1'b1;
            default:   cond = 1'b0;
        endcase
    end

    // One adder serves both branch and JALR targets
    assign is_jalr = dec_i.uop.br_cond == BR_ALWAYS;
    assign base    = is_jalr ? dec_i.operand_a : dec_i.pc;
    assign sum     = base + dec_i.imm;

    assign res_o.valid      = dec_i.valid;
    assign res_o.unit       = dec_i.uop.unit;
    assign res_o.rd         = dec_i.rd;
    assign res_o.alu_value  = alu_value;
    assign res_o.link_value = dec_i.pc + 32'd4;
    assign res_o.taken      = dec_i.valid && (dec_i.uop.unit != UNIT_ILLEGAL) && cond;
    assign res_o.target     = {sum[31:1], sum[0] & !is_jalr};  // JALR clears bit 0

endmodule

//--- logic/result_stage.sv
// Result stage; picks the rd value, blocks writes to x0 and registers the write-back and branch outputs
module result_stage (
    input  logic               clk_i,
    input  logic               rst_i,
    ex_res_if.receiver         res_i,
    output logic               wb_valid_o,
    output logic               wb_we_o,
    output isa_pkg::reg_addr_t wb_rd_o,
    output isa_pkg::word_t     wb_value_o,
    output isa_pkg::word_t     br_target_o,
    output logic               br_taken_o,
    output logic               illegal_o
);
    import isa_pkg::*;
    import exec_pkg::*;

    word_t value_d;
    logic  we_d;

    assign value_d = (res_i.unit == UNIT_JUMP) ? res_i.link_value : res_i.alu_value;
    // Branch rd arrives as zero from decode
    assign we_d    = res_i.valid && (res_i.unit != UNIT_ILLEGAL) && (res_i.rd != '0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
            br_taken_o <= 1'b0;
            illegal_o  <= 1'b0;
        end else begin
            wb_valid_o <= res_i.valid;
            wb_we_o    <= we_d;
            br_taken_o <= res_i.taken;
            illegal_o  <= res_i.valid && (res_i.unit == UNIT_ILLEGAL);
        end
    end

    always_ff @(posedge clk_i) begin
        wb_rd_o     <= res_i.rd;
        wb_value_o  <= value_d;
        br_target_o <= res_i.target;
    end

endmodule

//--- logic/exec_top.sv
// Top level of the execute pipeline; connects decode, execute and result stages behind plain ports
module exec_top (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               issue_valid_i,
    input  isa_pkg::instr_u    instr_i,
    input  isa_pkg::word_t     pc_i,
    input  isa_pkg::word_t     rs1_val_i,
    input  isa_pkg::word_t     rs2_val_i,
    output logic               wb_valid_o,
    output logic               wb_we_o,
    output isa_pkg::reg_addr_t wb_rd_o,
    output isa_pkg::word_t     wb_value_o,
    output logic               br_taken_o,
    output isa_pkg::word_t     br_target_o,
    output logic               illegal_o
);

    dec_ex_if dec_ex ();
    ex_res_if ex_res ();

    instr_decoder u_decoder (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .issue_valid_i(issue_valid_i),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .rs1_val_i    (rs1_val_i),
        .rs2_val_i    (rs2_val_i),
        .dec_o        (dec_ex.sender)
    );

    // Combinational, adds no cycle
    exec_unit u_exec (
        .dec_i(dec_ex.receiver),
        .res_o(ex_res.sender)
    );

    result_stage u_result (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .res_i      (ex_res.receiver),
        .wb_valid_o (wb_valid_o),
        .wb_we_o    (wb_we_o),
        .wb_rd_o    (wb_rd_o),
        .wb_value_o (wb_value_o),
        .br_target_o(br_target_o),
        .br_taken_o (br_taken_o),
        .illegal_o  (illegal_o)
    );

endmodule

//--- verification/tb_exec_top.sv
// Self-checking testbench for exec_top; random RV32I stimulus against a reference model, run as top
module tb_exec_top;
    import isa_pkg::*;

    typedef struct packed {
        logic [31:0] cycle;  // Cycle count when the result is due
        logic        we;
        reg_addr_t   rd;
        word_t       value;
        logic        is_jump;
        logic        taken;
        word_t       target;
        logic        illegal;
    } exp_t;

    logic      clk_i;
    logic      rst_i;
    logic      issue_valid_i;
    instr_u    instr_i;
    word_t     pc_i;
    word_t     rs1_val_i;
    word_t     rs2_val_i;
    logic      wb_valid_o;
    logic      wb_we_o;
    reg_addr_t wb_rd_o;
    word_t     wb_value_o;
    logic      br_taken_o;
    word_t     br_target_o;
    logic      illegal_o;

    exp_t        exp_q[$];
    string       name_q[$];
    logic [31:0] cycle_count = '0;
    logic [31:0] rng_state = 32'd96;

    exec_top DUT (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .issue_valid_i(issue_valid_i),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .rs1_val_i    (rs1_val_i),
        .rs2_val_i    (rs2_val_i),
        .wb_valid_o   (wb_valid_o),
        .wb_we_o      (wb_we_o),
        .wb_rd_o      (wb_rd_o),
        .wb_value_o   (wb_value_o),
        .br_taken_o   (br_taken_o),
        .br_target_o  (br_target_o),
        .illegal_o    (illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_count <= cycle_count + 32'd1;

    // xorshift32
    function logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Biased toward small values and sign boundaries
    function word_t pick_operand();
        logic [31:0] sel;
        logic [31:0] val;
        sel = next_random();
        val = next_random();
        case (sel[2:0])
            3'd0:    return {28'd0, val[3:0]};
            3'd1:    return {{28{1'b1}}, val[3:0]};
            3'd2:    return 32'h8000_0000 ^ {30'd0, val[1:0]};
            3'd3:    return 32'h7fff_ffff - {30'd0, val[1:0]};
            default: return val;
        endcase
    endfunction

    function word_t random_pc();
        word_t w;
        w = next_random();
        return {w[31:2], 2'b00};
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t r;
        case (f3)
            F3_ADD_SUB: r = alt ? a - b : a + b;
            F3_SLL:     r = a << b[4:0];
            F3_SLT:     r = {31'd0, $signed(a) < $signed(b)};
            F3_SLTU:    r = {31'd0, a < b};
            F3_XOR:     r = a ^ b;
            F3_SRL_SRA: begin
                if (alt) r = $signed(a) >>> b[4:0];
                else r = a >> b[4:0];
            end
            F3_OR:      r = a | b;
            default:    r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;  // BGEU
        endcase
    endfunction

    function automatic exp_t expected_result(input logic [31:0] w, input word_t pc,
                                             input word_t a, input word_t b);
        exp_t  e;
        word_t imm_i;
        word_t imm_b;
        word_t sum;
        logic  alt;
        e     = '0;
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        e.rd  = w[11:7];
        case (w[6:0])
            OPC_OP: begin
                e.value = alu_ref(w[14:12], w[30], a, b);
                e.we    = w[11:7] != 5'd0;
            end
            OPC_OP_IMM: begin
                alt     = (w[14:12] == F3_SRL_SRA) && w[30];  // Only SRAI has an alternate form
                e.value = alu_ref(w[14:12], alt, a, imm_i);
                e.we    = w[11:7] != 5'd0;
            end
            OPC_BRANCH: begin
                if (w[14:12] == 3'b010 || w[14:12] == 3'b011) begin
                    e.illegal = 1'b1;
                end else begin
                    e.is_jump = 1'b1;
                    e.taken   = branch_ref(w[14:12], a, b);
                    e.target  = pc + imm_b;
                end
            end
            OPC_JALR: begin
                sum       = a + imm_i;
                e.is_jump = 1'b1;
                e.taken   = 1'b1;
                e.target  = {sum[31:1], 1'b0};
                e.value   = pc + 32'd4;
                e.we      = w[11:7] != 5'd0;
            end
            default: e.illegal = 1'b1;
        endcase
        return e;
    endfunction

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on a failed check");
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        stop_with_failure();
    endtask

    task automatic check_word(input string test, input string field, input word_t exp,
                              input word_t act);
        if (act !== exp) begin
            $display("ERROR %s: %s expected %h actual %h", test, field, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(input string test, input string field, input reg_addr_t exp,
                             input reg_addr_t act);
        if (act !== exp) begin
            $display("ERROR %s: %s expected %0d actual %0d", test, field, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string test, input string field, input logic exp,
                              input logic act);
        if (act !== exp) begin
            $display("ERROR %s: %s expected %b actual %b", test, field, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic issue(input string name, input logic [31:0] w, input word_t pc,
                         input word_t a, input word_t b);
        exp_t e;
        @(negedge clk_i);
        issue_valid_i = 1'b1;
        instr_i       = w;
        pc_i          = pc;
        rs1_val_i     = a;
        rs2_val_i     = b;
        e             = expected_result(w, pc, a, b);
        e.cycle       = cycle_count + 32'd2;  // Fixed two-cycle latency
        exp_q.push_back(e);
        name_q.push_back(name);
    endtask

    // Garbage on the inputs must be ignored while valid is low
    task automatic idle_cycle();
        @(negedge clk_i);
        issue_valid_i = 1'b0;
        instr_i       = next_random();
        rs1_val_i     = next_random();
    endtask

    task automatic issue_r_type(input string name, input logic zero_rd);
        logic [31:0] w;
        w = next_random();
        w[6:0]   = OPC_OP;
        w[31:25] = w[25] ? F7_ALT : 7'd0;
        if (zero_rd) w[11:7] = 5'd0;
        issue(name, w, random_pc(), pick_operand(), pick_operand());
    endtask

    task automatic issue_i_type(input string name);
        logic [31:0] w;
        w = next_random();
        w[6:0] = OPC_OP_IMM;
        if (w[14:12] == F3_SLL) w[31:25] = 7'd0;
        else if (w[14:12] == F3_SRL_SRA) w[31:25] = w[25] ? F7_ALT : 7'd0;
        issue(name, w, random_pc(), pick_operand(), next_random());
    endtask

    task automatic issue_branch(input string name);
        logic [31:0] w;
        word_t       a;
        w = next_random();
        w[6:0] = OPC_BRANCH;
        if (w[14:12] == 3'b010 || w[14:12] == 3'b011) w[13] = 1'b0;  // Keep it legal
        a = pick_operand();
        issue(name, w, random_pc(), a, (w[21:20] == 2'd0) ? a : pick_operand());
    endtask

    task automatic issue_jalr(input string name, input logic zero_rd);
        logic [31:0] w;
        w = next_random();
        w[6:0]   = OPC_JALR;
        w[14:12] = 3'b000;
        if (zero_rd) w[11:7] = 5'd0;
        issue(name, w, random_pc(), pick_operand(), next_random());
    endtask

    task automatic issue_illegal(input string name);
        logic [31:0] w;
        w = next_random();
        if (w[31]) begin
            w[6:0]   = OPC_BRANCH;
            w[14:12] = {2'b01, w[30]};  // Reserved branch funct3
        end else if (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM || w[6:0] == OPC_BRANCH ||
                     w[6:0] == OPC_JALR) begin
            w[6:0] = w[6:0] ^ 7'b0001000;
        end
        issue(name, w, random_pc(), pick_operand(), pick_operand());
    endtask

    task automatic wait_for_drain(input int limit);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < limit) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0) report_failure("Timed out waiting for outstanding results");
    endtask

    always @(negedge clk_i) begin : compare_outputs
        exp_t  e;
        string name;
        if (!rst_i && wb_valid_o) begin
            if (exp_q.size() == 0) begin
                report_failure("A result came out with no instruction outstanding");
            end else begin
                e    = exp_q.pop_front();
                name = name_q.pop_front();
                if (e.cycle != cycle_count)
                    report_failure($sformatf("%s came out in cycle %0d instead of cycle %0d",
                                             name, cycle_count, e.cycle));
                check_flag(name, "wb_we", e.we, wb_we_o);
                check_flag(name, "br_taken", e.taken, br_taken_o);
                check_flag(name, "illegal", e.illegal, illegal_o);
                if (e.we) begin
                    check_reg(name, "wb_rd", e.rd, wb_rd_o);
                    check_word(name, "wb_value", e.value, wb_value_o);
                end
                if (e.is_jump) check_word(name, "br_target", e.target, br_target_o);
            end
        end else if (!rst_i) begin
            check_flag("idle", "wb_we", 1'b0, wb_we_o);
            check_flag("idle", "br_taken", 1'b0, br_taken_o);
            check_flag("idle", "illegal", 1'b0, illegal_o);
            if (exp_q.size() != 0 && exp_q[0].cycle == cycle_count)
                report_failure($sformatf("%s gave no result in its cycle", name_q[0]));
        end
    end

    initial begin : stimulus
        int          i;
        logic [31:0] r;
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        rs1_val_i     = '0;
        rs2_val_i     = '0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        repeat (2) @(negedge clk_i);
        check_flag("after_reset", "wb_valid", 1'b0, wb_valid_o);
        check_flag("after_reset", "wb_we", 1'b0, wb_we_o);
        check_flag("after_reset", "br_taken", 1'b0, br_taken_o);
        check_flag("after_reset", "illegal", 1'b0, illegal_o);

        for (i = 0; i < 200; i++) issue_r_type($sformatf("r_type_%0d", i), 1'b0);
        for (i = 0; i < 150; i++) issue_i_type($sformatf("i_type_%0d", i));
        for (i = 0; i < 150; i++) issue_branch($sformatf("branch_%0d", i));
        for (i = 0; i < 50; i++) issue_jalr($sformatf("jalr_%0d", i), 1'b0);
        for (i = 0; i < 10; i++) issue_r_type($sformatf("x0_r_type_%0d", i), 1'b1);
        for (i = 0; i < 5; i++) issue_jalr($sformatf("x0_jalr_%0d", i), 1'b1);
        for (i = 0; i < 30; i++) issue_illegal($sformatf("illegal_%0d", i));

        // Mixed traffic with gaps in issue
        for (i = 0; i < 100; i++) begin
            r = next_random();
            if (r[1:0] == 2'd0) repeat (r[3:2] + 1) idle_cycle();
            case (r[6:4])
                3'd0, 3'd1: issue_r_type($sformatf("mixed_%0d", i), r[7]);
                3'd2, 3'd3: issue_i_type($sformatf("mixed_%0d", i));
                3'd4:       issue_branch($sformatf("mixed_%0d", i));
                3'd5:       issue_jalr($sformatf("mixed_%0d", i), r[7]);
                default:    issue_illegal($sformatf("mixed_%0d", i));
            endcase
        end

        idle_cycle();
        wait_for_drain(10);
        repeat (3) idle_cycle();
        if (exp_q.size() != 0) begin
            report_failure("Results still outstanding at the end of the run");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

//--- tb.f
logic/isa_pkg.sv
logic/exec_pkg.sv
logic/exec_ifs.sv
logic/instr_decoder.sv
logic/exec_unit.sv
logic/result_stage.sv
logic/exec_top.sv
verification/tb_exec_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the execute pipeline testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing \
    --top-module tb_exec_top \
    --Mdir "$BUILD_DIR" \
    -o sim_exec_top \
    -f tb.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

"./$BUILD_DIR/sim_exec_top"
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
